// File: Makefile
TOP := dcache_tb

all: run

compile:
	verilator --binary --timing -f project.f --top-module $(TOP) -o sim

run: compile
	-./obj_dir/sim > sim.log 2>&1
	cat sim.log
	! grep -q "Regression failed" sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: project.f
+incdir+source
source/dcache_pkg.sv
source/cpu_dbus_if.sv
source/mem_axi_if.sv
source/single_port_ram.sv
source/dcache_fifo.sv
source/dcache.sv
source/dcache_top.sv
verification/axi_mem_model.sv
verification/dcache_tb.sv

// File: source/cpu_dbus_if.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

interface cpu_dbus_if;

    logic                     read;
    logic                     write;
    logic [`DC_WORD_BITS-1:0] address;
    logic [`DC_WORD_BITS-1:0] wrdata;
    logic [`DC_WORD_BITS-1:0] rddata;
    logic                     stall;

    modport cache (
        input  read, write, address, wrdata,
        output rddata, stall
    );

    modport cpu (
        output read, write, address, wrdata,
        input  rddata, stall
    );

endinterface

// File: source/dcache.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache
    import dcache_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    cpu_dbus_if.cache dbus,
    mem_axi_if.master mem
);

    localparam int LINE_BITS = `DC_LINE_WORDS * `DC_WORD_BITS;
    localparam int SET_BITS = $clog2(`DC_SETS);
    localparam int SEL_BITS = $clog2(`DC_LINE_WORDS);
    localparam int TAG_BITS = `DC_WORD_BITS - SET_BITS - SEL_BITS - $clog2(`DC_WORD_BITS / 8);
    localparam int WAY_BITS = $clog2(`DC_WAYS);

    localparam logic [2:0] S_IDLE = 3'd0, S_WRITE = 3'd1, S_REFILL = 3'd2;
    localparam logic [2:0] S_ADDR = 3'd3, S_RECV = 3'd4, S_FINISH = 3'd5;
    localparam logic [1:0] WB_IDLE = 2'd0, WB_ADDR = 2'd1, WB_DATA = 2'd2, WB_RESP = 2'd3;

    logic [2:0]                                           state, state_d;
    logic [1:0]                                           wb_state, wb_state_d;
    dc_addr_t                                             cpu_addr, pipe_addr;
    dc_addr_t                                             line_addr, victim_addr, fifo_head_addr;
    logic                                                 pipe_read, pipe_write, pipe_found;
    logic [`DC_WORD_BITS-1:0]                             pipe_wdata;
    logic [`DC_LINE_WORDS-1:0][`DC_WORD_BITS-1:0]         pipe_line, line_recv, fill_line;
    logic [`DC_LINE_WORDS-1:0][`DC_WORD_BITS-1:0]         data_wdata, fifo_head_line;
    logic [LINE_BITS-1:0]                                 fifo_query_line;
    logic [`DC_WAYS-1:0][`DC_LINE_WORDS-1:0][`DC_WORD_BITS-1:0] data_rdata;
    // Tag entry is valid, dirty, tag
    logic [`DC_WAYS-1:0][TAG_BITS+1:0]                    tag_rdata;
    logic [TAG_BITS+1:0]                                  tag_wdata;
    logic [`DC_WAYS-1:0]                                  hit, array_we;
    logic [WAY_BITS-1:0]                                  hit_way, victim;
    logic [SET_BITS-1:0]                                  ram_addr;
    logic                                                 miss, need_push, fill;
    logic [7:0]                                           lfsr;
    logic [SEL_BITS-1:0]                                  recv_cnt, wb_cnt;
    logic                                 fifo_push, fifo_pop, fifo_empty, fifo_full, fifo_found;

    assign cpu_addr = dc_addr_t'(dbus.address);

    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `DC_WAYS; i++) begin
            hit[i] = tag_rdata[i][TAG_BITS+1] && tag_rdata[i][TAG_BITS-1:0] == pipe_addr.f.tag;
            if (hit[i]) begin
                hit_way = WAY_BITS'(i);
            end
        end
    end

    assign miss = (pipe_read || pipe_write) && !(|hit);
    assign victim = lfsr[WAY_BITS-1:0];
    assign need_push = tag_rdata[victim][TAG_BITS+1] && tag_rdata[victim][TAG_BITS];
    assign dbus.rddata = data_rdata[hit_way][pipe_addr.f.word];
    assign dbus.stall = state_d != S_IDLE;
    // Look up the next request only when this one completes
    assign ram_addr = (state_d == S_IDLE) ? cpu_addr.f.index : pipe_addr.f.index;
    assign tag_wdata = {1'b1, pipe_write, pipe_addr.f.tag};

    always_comb begin
        line_addr = pipe_addr;
        line_addr.f.word = '0;
        line_addr.f.byte_off = '0;
        victim_addr = line_addr;
        victim_addr.f.tag = tag_rdata[victim][TAG_BITS-1:0];
        fill_line = line_recv;
        fill_line[recv_cnt] = mem.rdata;
        case (state)
            S_WRITE: data_wdata = data_rdata[hit_way];
            S_REFILL: data_wdata = pipe_line;
            default: data_wdata = fill_line;
        endcase
        if (pipe_write) begin
            data_wdata[pipe_addr.f.word] = pipe_wdata;
        end
    end

    always_comb begin
        state_d = state;
        array_we = '0;
        fifo_push = 1'b0;
        fill = 1'b0;
        case (state)
            S_IDLE: begin
                if (miss) begin
                    state_d = S_REFILL;
                end else if (pipe_write) begin
                    state_d = S_WRITE;
                end
            end
            S_WRITE: begin
                array_we = hit;
                state_d = S_FINISH;
            end
            // Dirty victim needs a free FIFO slot
            S_REFILL: begin
                if (!(need_push && fifo_full)) begin
                    fifo_push = need_push;
                    if (pipe_found) begin
                        fill = 1'b1;
                        state_d = S_FINISH;
                    end else begin
                        state_d = S_ADDR;
                    end
                end
            end
            S_ADDR: begin
                if (mem.arready) begin
                    state_d = S_RECV;
                end
            end
            S_RECV: begin
                if (mem.rvalid && mem.rlast) begin
                    fill = 1'b1;
                    state_d = S_FINISH;
                end
            end
            default: state_d = S_IDLE;
        endcase
        if (fill) begin
            array_we[victim] = 1'b1;
        end
    end

    assign mem.arvalid = state == S_ADDR;
    assign mem.araddr = line_addr.raw;
    assign mem.rready = state == S_RECV;

    // Write-back reads the FIFO head in place until the response
    always_comb begin
        wb_state_d = wb_state;
        fifo_pop = 1'b0;
        case (wb_state)
            WB_IDLE: if (!fifo_empty) wb_state_d = WB_ADDR;
            WB_ADDR: if (mem.awready) wb_state_d = WB_DATA;
            WB_DATA: if (mem.wready && mem.wlast) wb_state_d = WB_RESP;
            default: begin
                if (mem.bvalid) begin
                    fifo_pop = 1'b1;
                    wb_state_d = WB_IDLE;
                end
            end
        endcase
    end

    assign mem.awvalid = wb_state == WB_ADDR;
    assign mem.awaddr = fifo_head_addr.raw;
    assign mem.wvalid = wb_state == WB_DATA;
    assign mem.wdata = fifo_head_line[wb_cnt];
    assign mem.wlast = wb_cnt == SEL_BITS'(`DC_LINE_WORDS - 1);
    assign mem.bready = wb_state == WB_RESP;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            wb_state <= WB_IDLE;
            pipe_read <= 1'b0;
            pipe_write <= 1'b0;
            pipe_found <= 1'b0;
            lfsr <= 8'h01;
            recv_cnt <= '0;
            wb_cnt <= '0;
        end else begin
            state <= state_d;
            wb_state <= wb_state_d;
            if (!dbus.stall) begin
                pipe_read <= dbus.read;
                pipe_write <= dbus.write;
                pipe_found <= fifo_found;
            end
            if (fill) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
            if (state == S_ADDR) begin
                recv_cnt <= '0;
            end else if (mem.rvalid && mem.rready) begin
                recv_cnt <= recv_cnt + 1'b1;
            end
            if (wb_state == WB_ADDR) begin
                wb_cnt <= '0;
            end else if (mem.wvalid && mem.wready) begin
                wb_cnt <= wb_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!dbus.stall) begin
            pipe_addr <= cpu_addr;
            pipe_wdata <= dbus.wrdata;
            pipe_line <= fifo_query_line;
        end
        if (mem.rvalid && mem.rready) begin
            line_recv[recv_cnt] <= mem.rdata;
        end
    end

    for (genvar i = 0; i < `DC_WAYS; i++) begin : gen_way
        single_port_ram #(.DEPTH(`DC_SETS), .WIDTH(TAG_BITS + 2)) tag_ram (
            .clk, .rst, .we(array_we[i]), .addr(ram_addr), .din(tag_wdata), .dout(tag_rdata[i])
        );
        single_port_ram #(.DEPTH(`DC_SETS), .WIDTH(LINE_BITS)) data_ram (
            .clk, .rst, .we(array_we[i]), .addr(ram_addr), .din(data_wdata), .dout(data_rdata[i])
        );
    end

    dcache_fifo fifo_inst (
        .clk, .rst,
        .push(fifo_push), .pop(fifo_pop),
        .push_addr(victim_addr), .push_line(data_rdata[victim]),
        .head_addr(fifo_head_addr), .head_line(fifo_head_line),
        .empty(fifo_empty), .full(fifo_full),
        .query_tag(cpu_addr), .query_found(fifo_found), .query_line(fifo_query_line)
    );

endmodule

// File: source/dcache_fifo.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_fifo
    import dcache_pkg::*;
(
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      push,
    input  logic                                      pop,
    input  dc_addr_t                                  push_addr,
    input  logic [`DC_LINE_WORDS*`DC_WORD_BITS-1:0]   push_line,
    output dc_addr_t                                  head_addr,
    output logic [`DC_LINE_WORDS*`DC_WORD_BITS-1:0]   head_line,
    output logic                                      empty,
    output logic                                      full,
    input  dc_addr_t                                  query_tag,
    output logic                                      query_found,
    output logic [`DC_LINE_WORDS*`DC_WORD_BITS-1:0]   query_line
);

    localparam int DEPTH = `DC_FIFO_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);

    dc_addr_t                                    addr_q [DEPTH];
    logic [`DC_LINE_WORDS*`DC_WORD_BITS-1:0]     line_q [DEPTH];
    logic [DEPTH-1:0]                            valid_q;
    logic [PTR_BITS-1:0]                         head, tail;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign empty = ~valid_q[head];
    assign full = valid_q[tail];
    assign head_addr = addr_q[head];
    assign head_line = line_q[head];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            head <= '0;
            tail <= '0;
        end else begin
            if (push && !full) begin
                valid_q[tail] <= 1'b1;
                tail <= next_ptr(tail);
            end
            if (pop && !empty) begin
                valid_q[head] <= 1'b0;
                head <= next_ptr(head);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !full) begin
            addr_q[tail] <= push_addr;
            line_q[tail] <= push_line;
        end
    end

    // Walk from head to tail so the youngest match wins
    always_comb begin
        int idx;
        query_found = 1'b0;
        query_line = '0;
        for (int i = 0; i < DEPTH; i++) begin
            idx = (int'(head) + i) % DEPTH;
            if (valid_q[idx] && addr_q[idx].f.tag == query_tag.f.tag
                    && addr_q[idx].f.index == query_tag.f.index) begin
                query_found = 1'b1;
                query_line = line_q[idx];
            end
        end
    end

endmodule

// File: source/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// CPU word and bus beat width
`define DC_WORD_BITS 32

// Words per line, also beats per burst
`define DC_LINE_WORDS 4

`define DC_SETS 16
`define DC_WAYS 2

// Victim lines waiting for write-back
`define DC_FIFO_DEPTH 2

`endif

// File: source/dcache_pkg.sv
package dcache_pkg;

    // Address fields, high bits first
    typedef struct packed {
        logic [23:0] tag;
        logic [3:0]  index;
        logic [1:0]  word;
        logic [1:0]  byte_off;
    } dc_addr_fields_t;

    // Raw bus address or split into cache fields
    typedef union packed {
        logic [31:0]     raw;
        dc_addr_fields_t f;
    } dc_addr_t;

endpackage

// File: source/dcache_top.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_read,
    input  logic                     cpu_write,
    input  logic [`DC_WORD_BITS-1:0] cpu_address,
    input  logic [`DC_WORD_BITS-1:0] cpu_wrdata,
    output logic [`DC_WORD_BITS-1:0] cpu_rddata,
    output logic                     cpu_stall,
    output logic                     arvalid,
    input  logic                     arready,
    output logic [`DC_WORD_BITS-1:0] araddr,
    input  logic                     rvalid,
    output logic                     rready,
    input  logic [`DC_WORD_BITS-1:0] rdata,
    input  logic                     rlast,
    output logic                     awvalid,
    input  logic                     awready,
    output logic [`DC_WORD_BITS-1:0] awaddr,
    output logic                     wvalid,
    input  logic                     wready,
    output logic [`DC_WORD_BITS-1:0] wdata,
    output logic                     wlast,
    input  logic                     bvalid,
    output logic                     bready
);

    cpu_dbus_if dbus ();
    mem_axi_if mem ();

    // CPU side
    assign dbus.read = cpu_read;
    assign dbus.write = cpu_write;
    assign dbus.address = cpu_address;
    assign dbus.wrdata = cpu_wrdata;
    assign cpu_rddata = dbus.rddata;
    assign cpu_stall = dbus.stall;

    // Memory side
    assign arvalid = mem.arvalid;
    assign mem.arready = arready;
    assign araddr = mem.araddr;
    assign mem.rvalid = rvalid;
    assign rready = mem.rready;
    assign mem.rdata = rdata;
    assign mem.rlast = rlast;
    assign awvalid = mem.awvalid;
    assign mem.awready = awready;
    assign awaddr = mem.awaddr;
    assign wvalid = mem.wvalid;
    assign mem.wready = wready;
    assign wdata = mem.wdata;
    assign wlast = mem.wlast;
    assign mem.bvalid = bvalid;
    assign bready = mem.bready;

    dcache dcache_inst (
        .clk,
        .rst,
        .dbus(dbus.cache),
        .mem(mem.master)
    );

endmodule

// File: source/mem_axi_if.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

interface mem_axi_if;

    logic                     arvalid;
    logic                     arready;
    logic [`DC_WORD_BITS-1:0] araddr;
    logic                     rvalid;
    logic                     rready;
    logic [`DC_WORD_BITS-1:0] rdata;
    logic                     rlast;
    logic                     awvalid;
    logic                     awready;
    logic [`DC_WORD_BITS-1:0] awaddr;
    logic                     wvalid;
    logic                     wready;
    logic [`DC_WORD_BITS-1:0] wdata;
    logic                     wlast;
    logic                     bvalid;
    logic                     bready;

    modport master (
        output arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wlast, bready,
        input  arready, rvalid, rdata, rlast, awready, wready, bvalid
    );

    modport slave (
        input  arvalid, araddr, rready, awvalid, awaddr, wvalid, wdata, wlast, bready,
        output arready, rvalid, rdata, rlast, awready, wready, bvalid
    );

endinterface

// File: source/single_port_ram.sv
`timescale 1ns/1ns

module single_port_ram #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    // Block RAM powers up cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // Write-first, so a written entry shows on dout next cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        if (rst) begin
            dout <= '0;
        end else if (we) begin
            dout <= din;
        end else begin
            dout <= mem[addr];
        end
    end

endmodule

// File: verification/axi_mem_model.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module axi_mem_model (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     arvalid,
    output logic                     arready,
    input  logic [`DC_WORD_BITS-1:0] araddr,
    output logic                     rvalid,
    input  logic                     rready,
    output logic [`DC_WORD_BITS-1:0] rdata,
    output logic                     rlast,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`DC_WORD_BITS-1:0] awaddr,
    input  logic                     wvalid,
    output logic                     wready,
    input  logic [`DC_WORD_BITS-1:0] wdata,
    input  logic                     wlast,
    output logic                     bvalid,
    input  logic                     bready,
    output int                       burst_errors
);

    localparam int LINE_BYTES = `DC_LINE_WORDS * `DC_WORD_BITS / 8;

    // Sparse memory where untouched words read as the inverted address
    logic [`DC_WORD_BITS-1:0] mem [logic [`DC_WORD_BITS-1:0]];
    logic [`DC_WORD_BITS-1:0] rd_addr;
    logic [`DC_WORD_BITS-1:0] wr_addr;
    int                       rd_cnt;
    int                       wr_cnt;
    logic                     rd_busy;
    logic                     wr_busy;
    logic                     resp_due;
    logic                     r_hold;
    logic                     b_hold;

    function automatic logic [`DC_WORD_BITS-1:0] load(input logic [`DC_WORD_BITS-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return ~a;
    endfunction

    initial begin
        arready = 1'b0;
        rvalid = 1'b0;
        rdata = '0;
        rlast = 1'b0;
        awready = 1'b0;
        wready = 1'b0;
        bvalid = 1'b0;
        burst_errors = 0;
        rd_busy = 1'b0;
        wr_busy = 1'b0;
        resp_due = 1'b0;
        rd_cnt = 0;
        wr_cnt = 0;
        rd_addr = '0;
        wr_addr = '0;
        forever begin
            @(posedge clk);
            r_hold = rvalid && !rready;
            b_hold = bvalid && !bready;
            if (rst) begin
                rd_busy = 1'b0;
                wr_busy = 1'b0;
                resp_due = 1'b0;
                r_hold = 1'b0;
                b_hold = 1'b0;
            end else begin
                // A new refill must wait for every beat of the previous one
                if (arvalid && rd_busy) begin
                    burst_errors++;
                    $display("read address issued after %0d of %0d burst beats",
                             rd_cnt, `DC_LINE_WORDS);
                end
                if (arvalid && arready) begin
                    rd_busy = 1'b1;
                    rd_addr = araddr;
                    rd_cnt = 0;
                    if ((araddr % 32'(LINE_BYTES)) != 0) begin
                        burst_errors++;
                        $display("read burst address %h is not line aligned", araddr);
                    end
                end
                if (rvalid && rready) begin
                    rd_cnt++;
                    if (rlast) begin
                        rd_busy = 1'b0;
                    end
                end
                if (awvalid && awready) begin
                    wr_busy = 1'b1;
                    wr_addr = awaddr;
                    wr_cnt = 0;
                    if ((awaddr % 32'(LINE_BYTES)) != 0) begin
                        burst_errors++;
                        $display("write burst address %h is not line aligned", awaddr);
                    end
                end
                if (wvalid && wready) begin
                    mem[wr_addr + 32'(4 * wr_cnt)] = wdata;
                    wr_cnt++;
                    if (wlast != (wr_cnt == `DC_LINE_WORDS)) begin
                        burst_errors++;
                        $display("write burst has last flag %0b on beat %0d of %0d",
                                 wlast, wr_cnt, `DC_LINE_WORDS);
                    end
                    if (wlast || wr_cnt == `DC_LINE_WORDS) begin
                        wr_busy = 1'b0;
                        resp_due = 1'b1;
                    end
                end
                if (bvalid && bready) begin
                    resp_due = 1'b0;
                end
            end
            #5;
            // Random ready and valid delays
            // Valid holds until taken
            arready = !rd_busy && ($urandom % 2 == 1);
            rvalid = rd_busy && (r_hold || ($urandom % 2 == 1));
            rdata = load(rd_addr + 32'(4 * rd_cnt));
            rlast = rd_cnt == `DC_LINE_WORDS - 1;
            awready = !wr_busy && !resp_due && ($urandom % 2 == 1);
            wready = wr_busy && ($urandom % 2 == 1);
            bvalid = resp_due && (b_hold || ($urandom % 2 == 1));
        end
    end

endmodule

// File: verification/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_tb
    import dcache_pkg::*;
();

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     cpu_read;
    logic                     cpu_write;
    logic [`DC_WORD_BITS-1:0] cpu_address;
    logic [`DC_WORD_BITS-1:0] cpu_wrdata;
    logic [`DC_WORD_BITS-1:0] cpu_rddata;
    logic                     cpu_stall;
    logic                     arvalid, arready, rvalid, rready, rlast;
    logic                     awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic [`DC_WORD_BITS-1:0] araddr, rdata, awaddr, wdata;
    int                       burst_errors;
    int                       pass_count = 0;
    int                       fail_count = 0;
    logic                     hung = 1'b0;

    // Reference memory, every CPU write lands here
    logic [`DC_WORD_BITS-1:0] model_mem [logic [`DC_WORD_BITS-1:0]];

    always #50 clk = ~clk;

    dcache_top uut (.*);

    axi_mem_model mem_model (.*);

    function automatic logic [`DC_WORD_BITS-1:0] expected_word(
        input logic [`DC_WORD_BITS-1:0] a
    );
        if (model_mem.exists(a)) begin
            return model_mem[a];
        end
        return ~a;
    endfunction

    task automatic check_word(input string name, input dc_addr_t expected, input dc_addr_t actual);
        if (actual.raw === expected.raw) begin
            pass_count++;
            $display("pass %s: %h", name, actual.raw);
        end else begin
            fail_count++;
            $display("mismatch %s: expected %h, actual %h", name, expected.raw, actual.raw);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual === expected) begin
            pass_count++;
            $display("pass %s: %b", name, actual);
        end else begin
            fail_count++;
            $display("mismatch %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    // Samples stall at the falling edge, where it has settled
    task automatic wait_for_stall_low(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cpu_stall && !hung) begin
            cycles++;
            if (cycles > 2000) begin
                $display("timeout: %s still stalled after 2000 cycles", name);
                hung = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
    endtask

    // Starts and ends 5 ns after a rising edge
    task automatic access(input string name, input logic is_write, input dc_addr_t addr,
                          input logic [`DC_WORD_BITS-1:0] data);
        dc_addr_t want;
        dc_addr_t got;
        if (hung) return;
        cpu_read = !is_write;
        cpu_write = is_write;
        cpu_address = addr.raw;
        cpu_wrdata = data;
        wait_for_stall_low(name);
        if (hung) return;
        @(posedge clk);
        #5;
        cpu_read = 1'b0;
        cpu_write = 1'b0;
        wait_for_stall_low(name);
        if (hung) return;
        if (is_write) begin
            model_mem[addr.raw] = data;
        end else begin
            want.raw = expected_word(addr.raw);
            got.raw = cpu_rddata;
            check_word(name, want, got);
        end
        @(posedge clk);
        #5;
    endtask

    initial begin
        dc_addr_t                 a;
        logic [`DC_WORD_BITS-1:0] untouched [4];
        logic [`DC_WORD_BITS-1:0] value;
        void'($urandom(32'h8386c46a));
        rst = 1'b1;
        cpu_read = 1'b0;
        cpu_write = 1'b0;
        cpu_address = '0;
        cpu_wrdata = '0;
        repeat (16) @(posedge clk);
        #5;
        rst = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_flag("reset cpu_stall", 1'b0, cpu_stall);
        check_flag("reset arvalid", 1'b0, arvalid);
        check_flag("reset rready", 1'b0, rready);
        check_flag("reset awvalid", 1'b0, awvalid);
        check_flag("reset wvalid", 1'b0, wvalid);
        @(posedge clk);
        #5;

        untouched = '{32'h0000_1000, 32'h0000_2044, 32'h00ab_c0f8, 32'h1234_5678};
        for (int i = 0; i < 4; i++) begin
            a.raw = untouched[i];
            access($sformatf("untouched miss %0d", i), 1'b0, a, '0);
            access($sformatf("untouched hit %0d", i), 1'b0, a, '0);
        end

        a.raw = 32'h0000_2048;
        value = $urandom;
        access("line write", 1'b1, a, value);
        access("write readback", 1'b0, a, '0);
        for (int w = 0; w < `DC_LINE_WORDS; w++) begin
            a.f.word = 2'(w);
            access($sformatf("same line word %0d", w), 1'b0, a, '0);
        end

        // Eight tags over two sets, four ways' worth of pressure per set
        for (int n = 0; n < 300; n++) begin
            a.raw = '0;
            a.f.tag = 24'h00c000 + 24'($urandom % 8);
            a.f.index = ($urandom % 2 == 0) ? 4'd3 : 4'd11;
            a.f.word = 2'($urandom % 4);
            if ($urandom % 3 == 0) begin
                access($sformatf("random write %0d", n), 1'b1, a, $urandom);
            end else begin
                access($sformatf("random read %0d", n), 1'b0, a, '0);
            end
        end

        check_flag("burst protocol errors", 1'b0, burst_errors != 0);
        check_flag("stall wait timeout", 1'b0, hung);
        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
